/* source/order_pkg.sv */
`default_nettype none

package order_pkg;

    // ================================================
    // Request side
    // ================================================

    // Byte address of a memory request
    typedef logic [31:0] addr_t;

    // Request tag, 16 tags in flight at most
    typedef logic [3:0] tag_t;

    // Request as seen on the port
    typedef struct packed {
        tag_t  tag;
        addr_t addr;
    } req_t;

    // Response only needs the tag back
    typedef struct packed {
        tag_t tag;
    } rsp_t;

    // Verdict returned one cycle after the request
    typedef struct packed {
        tag_t tag;
        logic conflict;
        logic reject;
    } verdict_t;

    // ================================================
    // Configuration and statistics
    // ================================================

    // hash_sel picks plain or XOR-folded bucket hash
    typedef struct packed {
        logic hash_sel;
        logic conflict_en;
    } cfg_t;

    // Saturating event counters
    typedef struct packed {
        logic [15:0] n_accept;
        logic [15:0] n_conflict;
        logic [15:0] n_reject;
    } stats_t;

endpackage

`default_nettype wire

/* source/counting_filter.sv */
`timescale 1ns/1ns
`default_nettype none

module counting_filter
#(
    // Number of buckets, a power of two
    parameter int N_BUCKETS = 16,
    // Width of each bucket counter
    parameter int BITS_PER_BUCKET = 3
)
(
    input  logic                         clk,
    input  logic                         reset,

    // Test port, combinational in the same cycle
    input  logic [$clog2(N_BUCKETS)-1:0] test_idx,
    output logic                         test_not_full,
    output logic                         test_is_zero,

    // Insert port, counts up at the edge
    input  logic [$clog2(N_BUCKETS)-1:0] insert_idx,
    input  logic                         insert_en,

    // Remove port, counts down at the edge
    input  logic [$clog2(N_BUCKETS)-1:0] remove_idx,
    input  logic                         remove_en
);

    // One counter per bucket
    logic [BITS_PER_BUCKET-1:0] counters [N_BUCKETS];

    // Per-bucket match against the insert and remove ports
    logic [N_BUCKETS-1:0] bump_up;
    logic [N_BUCKETS-1:0] bump_down;

    // ================================================
    // Test port
    // ================================================

    // Not full means top bit clear, which leaves headroom for one more insert
    assign test_not_full = !counters[test_idx][BITS_PER_BUCKET-1];
    assign test_is_zero  = (counters[test_idx] == '0);

    // ================================================
    // Update
    // ================================================

    always_comb
    begin
        for (int b = 0; b < N_BUCKETS; b++)
        begin
            bump_up[b]   = insert_en && (int'(insert_idx) == b);
            bump_down[b] = remove_en && (int'(remove_idx) == b);
        end
    end

    for (genvar b = 0; b < N_BUCKETS; b++)
    begin : g_bucket
        // Insert and remove on the same bucket cancel out
        always_ff @(posedge clk)
        begin
            if (reset)
            begin
                counters[b] <= '0;
            end
            else
            begin
                counters[b] <= counters[b]
                               + BITS_PER_BUCKET'(bump_up[b])
                               - BITS_PER_BUCKET'(bump_down[b]);
            end
        end

        // Tracker must reject before the counter reaches its maximum
        a_no_wrap_up: assert property (@(posedge clk) disable iff (reset)
            (bump_up[b] && !bump_down[b]) |-> (counters[b] != '1))
            else $error("counting_filter: bucket %0d wraps up", b);

        // A remove must match an earlier insert to the same bucket
        a_no_wrap_down: assert property (@(posedge clk) disable iff (reset)
            (bump_down[b] && !bump_up[b]) |-> (counters[b] != '0))
            else $error("counting_filter: bucket %0d wraps down", b);
    end

endmodule

`default_nettype wire

/* source/tag_table.sv */
`timescale 1ns/1ns
`default_nettype none

module tag_table
#(
    // Number of filter buckets
    parameter int N_BUCKETS = 16
)
(
    input  logic                         clk,
    input  logic                         reset,

    // Allocation from an accepted request
    input  logic                         alloc_en,
    input  order_pkg::tag_t              alloc_tag,
    input  logic [$clog2(N_BUCKETS)-1:0] alloc_bucket,

    // Free on response, bucket read back combinationally
    input  logic                         free_en,
    input  order_pkg::tag_t              free_tag,
    output logic [$clog2(N_BUCKETS)-1:0] free_bucket
);

    import order_pkg::*;

    localparam int N_TAGS = 2 ** $bits(tag_t);
    localparam int IDX_W  = $clog2(N_BUCKETS);

    // Outstanding flag per tag
    logic [N_TAGS-1:0] pending;

    // Bucket recorded at allocation
    logic [IDX_W-1:0]  bucket_mem [N_TAGS];

    assign free_bucket = bucket_mem[free_tag];

    // Free first so that an alloc of the same tag wins
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            pending <= '0;
        end
        else
        begin
            if (free_en)
                pending[free_tag] <= 1'b0;
            if (alloc_en)
                pending[alloc_tag] <= 1'b1;
        end
    end

    always_ff @(posedge clk)
    begin
        if (alloc_en)
            bucket_mem[alloc_tag] <= alloc_bucket;
    end

    // Caller reused a tag whose response has not come back
    a_alloc_pending: assert property (@(posedge clk) disable iff (reset)
        alloc_en |-> (!pending[alloc_tag] || (free_en && free_tag == alloc_tag)))
        else $error("tag_table: tag %0d allocated while pending", alloc_tag);

    // Response for a tag that was rejected or never issued
    a_free_idle: assert property (@(posedge clk) disable iff (reset)
        free_en |-> pending[free_tag])
        else $error("tag_table: tag %0d freed while not pending", free_tag);

endmodule

`default_nettype wire

/* source/order_tracker.sv */
`timescale 1ns/1ns
`default_nettype none

module order_tracker
#(
    // Number of filter buckets
    parameter int N_BUCKETS = 16
)
(
    input  logic                         clk,
    input  logic                         reset,

    // Incoming request strobe
    input  logic                         req_valid,
    input  order_pkg::req_t              req,

    // Live configuration
    input  order_pkg::cfg_t              cfg,

    // Filter test port
    output logic [$clog2(N_BUCKETS)-1:0] test_idx,
    input  logic                         test_not_full,
    input  logic                         test_is_zero,

    // Filter insert port, also the tag table alloc port
    output logic [$clog2(N_BUCKETS)-1:0] insert_idx,
    output logic                         insert_en,

    // Registered verdict
    output logic                         verdict_valid,
    output order_pkg::verdict_t          verdict
);

    import order_pkg::*;

    localparam int IDX_W = $clog2(N_BUCKETS);

    // Bucket picked from the address
    logic [IDX_W-1:0] bucket;

    // Verdict formed in the request cycle
    logic     reject;
    logic     conflict;
    verdict_t verdict_next;

    // ================================================
    // Hash and test
    // ================================================

    // Low field alone, or low field folded with the next field up
    always_comb
    begin
        if (cfg.hash_sel)
            bucket = req.addr[IDX_W-1:0] ^ req.addr[2*IDX_W-1:IDX_W];
        else
            bucket = req.addr[IDX_W-1:0];
    end

    assign test_idx = bucket;

    // Counts tested here are those before this edge
    assign reject   = !test_not_full;
    assign conflict = !reject && !test_is_zero && cfg.conflict_en;

    // Only accepted requests are recorded
    assign insert_idx = bucket;
    assign insert_en  = req_valid && !reject;

    always_comb
    begin
        verdict_next          = '0;
        verdict_next.tag      = req.tag;
        verdict_next.conflict = conflict;
        verdict_next.reject   = reject;
    end

    // ================================================
    // Verdict register
    // ================================================

    // Strobe one cycle after the request
    always_ff @(posedge clk)
    begin
        if (reset)
            verdict_valid <= 1'b0;
        else
            verdict_valid <= req_valid;
    end

    // Payload only loads on a request
    always_ff @(posedge clk)
    begin
        if (req_valid)
            verdict <= verdict_next;
    end

endmodule

`default_nettype wire

/* source/order_csr.sv */
`timescale 1ns/1ns
`default_nettype none

module order_csr
(
    input  logic                clk,
    input  logic                reset,

    // Configuration write strobe
    input  logic                cfg_wr,
    input  order_pkg::cfg_t     cfg_in,
    output order_pkg::cfg_t     cfg,

    // Verdicts observed from the tracker
    input  logic                verdict_valid,
    input  order_pkg::verdict_t verdict,

    // Event counters as a level
    output order_pkg::stats_t   stats
);

    import order_pkg::*;

    // Plain hash, conflicts reported
    localparam cfg_t CFG_RESET = '{hash_sel: 1'b0, conflict_en: 1'b1};

    // Counter increment, holds at all ones
    function automatic logic [15:0] sat_inc(input logic [15:0] value);
        if (value == '1)
            return value;
        return value + 16'd1;
    endfunction

    // ================================================
    // Configuration register
    // ================================================

    // Takes effect for requests on the following cycle
    always_ff @(posedge clk)
    begin
        if (reset)
            cfg <= CFG_RESET;
        else if (cfg_wr)
            cfg <= cfg_in;
    end

    // ================================================
    // Statistics
    // ================================================

    // Accepted counts every non-rejected request, conflicting or not
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            stats <= '0;
        end
        else if (verdict_valid)
        begin
            if (verdict.reject)
                stats.n_reject <= sat_inc(stats.n_reject);
            else
                stats.n_accept <= sat_inc(stats.n_accept);
            if (verdict.conflict)
                stats.n_conflict <= sat_inc(stats.n_conflict);
        end
    end

endmodule

`default_nettype wire

/* source/order_filter_top.sv */
`timescale 1ns/1ns
`default_nettype none

module order_filter_top
#(
    parameter int N_BUCKETS       = 16,
    parameter int BITS_PER_BUCKET = 3
)
(
    input  logic                clk,
    input  logic                reset,

    // Caller side strobes
    input  logic                req_valid,
    input  order_pkg::req_t     req,
    input  logic                rsp_valid,
    input  order_pkg::rsp_t     rsp,

    // Configuration write
    input  logic                cfg_wr,
    input  order_pkg::cfg_t     cfg_in,

    // Results
    output logic                verdict_valid,
    output order_pkg::verdict_t verdict,
    output order_pkg::stats_t   stats
);

    import order_pkg::*;

    localparam int IDX_W = $clog2(N_BUCKETS);

    cfg_t             cfg;
    logic [IDX_W-1:0] test_idx;
    logic             test_not_full;
    logic             test_is_zero;
    logic [IDX_W-1:0] insert_idx;
    logic             insert_en;

    // Bucket of the tag being answered
    logic [IDX_W-1:0] remove_idx;

    // ================================================
    // Request path
    // ================================================

    order_tracker #(
        .N_BUCKETS     (N_BUCKETS)
    ) order_tracker_i (
        .clk           (clk),
        .reset         (reset),
        .req_valid     (req_valid),
        .req           (req),
        .cfg           (cfg),
        .test_idx      (test_idx),
        .test_not_full (test_not_full),
        .test_is_zero  (test_is_zero),
        .insert_idx    (insert_idx),
        .insert_en     (insert_en),
        .verdict_valid (verdict_valid),
        .verdict       (verdict)
    );

    counting_filter #(
        .N_BUCKETS       (N_BUCKETS),
        .BITS_PER_BUCKET (BITS_PER_BUCKET)
    ) counting_filter_i (
        .clk           (clk),
        .reset         (reset),
        .test_idx      (test_idx),
        .test_not_full (test_not_full),
        .test_is_zero  (test_is_zero),
        .insert_idx    (insert_idx),
        .insert_en     (insert_en),
        .remove_idx    (remove_idx),
        .remove_en     (rsp_valid)
    );

    // Accepted request allocates its tag in the same cycle
    tag_table #(
        .N_BUCKETS    (N_BUCKETS)
    ) tag_table_i (
        .clk          (clk),
        .reset        (reset),
        .alloc_en     (insert_en),
        .alloc_tag    (req.tag),
        .alloc_bucket (insert_idx),
        .free_en      (rsp_valid),
        .free_tag     (rsp.tag),
        .free_bucket  (remove_idx)
    );

    order_csr order_csr_i (
        .clk           (clk),
        .reset         (reset),
        .cfg_wr        (cfg_wr),
        .cfg_in        (cfg_in),
        .cfg           (cfg),
        .verdict_valid (verdict_valid),
        .verdict       (verdict),
        .stats         (stats)
    );

endmodule

`default_nettype wire

/* dv/order_filter_checker.sv */
`timescale 1ns/1ns
`default_nettype none

module order_filter_checker
#(
    parameter int N_BUCKETS       = 16,
    parameter int BITS_PER_BUCKET = 3,
    parameter int NAME_W          = 256
)
(
    input  logic                clk,
    input  logic                reset,

    // DUT ports watched only
    input  logic                req_valid,
    input  order_pkg::req_t     req,
    input  logic                rsp_valid,
    input  order_pkg::rsp_t     rsp,
    input  logic                cfg_wr,
    input  order_pkg::cfg_t     cfg_in,
    input  logic                verdict_valid,
    input  order_pkg::verdict_t verdict,
    input  order_pkg::stats_t   stats,

    // Expected flags from the stimulus table that arrive with the request
    input  logic                exp_check,
    input  logic                exp_conflict,
    input  logic                exp_reject,
    input  logic [NAME_W-1:0]   exp_name,

    output int                  mismatch_count,
    output int                  error_count
);

    import order_pkg::*;

    // A bucket rejects once its count reaches half the counter range
    localparam int REJECT_AT = 1 << (BITS_PER_BUCKET - 1);
    localparam int N_TAGS    = 16;

    // Model state
    int     counts [N_BUCKETS];
    int     tag_bucket [N_TAGS];
    cfg_t   cfg_model;
    stats_t stats_model;
    int     b;

    // Request waiting for its verdict
    logic              pend_valid;
    tag_t              pend_tag;
    logic              pend_conflict;
    logic              pend_reject;
    logic              pend_check;
    logic              pend_exp_conflict;
    logic              pend_exp_reject;
    logic [NAME_W-1:0] pend_name;

    // Bucket from the address as plain or folded with the next field up
    function automatic int bucket_of(input addr_t addr, input logic hash_sel);
        int low;
        int high;
        low  = int'(addr % 32'(N_BUCKETS));
        high = int'((addr / 32'(N_BUCKETS)) % 32'(N_BUCKETS));
        return hash_sel ? (low ^ high) : low;
    endfunction

    function automatic logic [15:0] bump(input logic [15:0] value);
        return (value == 16'hffff) ? value : value + 16'd1;
    endfunction

    task automatic check_value(input string what, input int expected, input int actual);
        if (expected != actual)
        begin
            mismatch_count++;
            $display("mismatch %s %s: expected %0d actual %0d",
                     pend_name, what, expected, actual);
        end
    endtask

    // ==================================================
    // Sampling at the falling edge between DUT updates
    // ==================================================

    always @(negedge clk)
    begin
        // Reset not yet driven counts as reset
        if (reset !== 1'b0)
        begin
            foreach (counts[i])
                counts[i] = 0;
            cfg_model   = '{hash_sel: 1'b0, conflict_en: 1'b1};
            stats_model = '0;
            pend_valid  = 1'b0;
        end
        else
        begin
            // Stats hold every verdict seen before this edge
            if (stats !== stats_model)
            begin
                mismatch_count++;
                $display("mismatch stats: expected %h actual %h", stats_model, stats);
            end

            // Verdict for the request of the previous cycle
            if (pend_valid)
            begin
                if (verdict_valid !== 1'b1)
                begin
                    error_count++;
                    $display("verdict_valid did not rise one cycle after request %s", pend_name);
                end
                else
                begin
                    check_value("tag", int'(pend_tag), int'(verdict.tag));
                    check_value("conflict", int'(pend_conflict), int'(verdict.conflict));
                    check_value("reject", int'(pend_reject), int'(verdict.reject));
                    if (pend_check)
                    begin
                        check_value("table conflict", int'(pend_exp_conflict),
                                    int'(verdict.conflict));
                        check_value("table reject", int'(pend_exp_reject),
                                    int'(verdict.reject));
                    end
                end
                if (pend_reject)
                    stats_model.n_reject = bump(stats_model.n_reject);
                else
                    stats_model.n_accept = bump(stats_model.n_accept);
                if (pend_conflict)
                    stats_model.n_conflict = bump(stats_model.n_conflict);
            end
            else if (verdict_valid !== 1'b0)
            begin
                error_count++;
                $display("verdict_valid rose without a request in the cycle before");
            end

            // New request tests the count as it stands now
            pend_valid = req_valid;
            if (req_valid)
            begin
                b                 = bucket_of(req.addr, cfg_model.hash_sel);
                pend_tag          = req.tag;
                pend_reject       = (counts[b] >= REJECT_AT);
                pend_conflict     = !pend_reject && (counts[b] != 0) && cfg_model.conflict_en;
                pend_check        = exp_check;
                pend_exp_conflict = exp_conflict;
                pend_exp_reject   = exp_reject;
                pend_name         = exp_name;
            end

            // Response frees the bucket recorded for its tag
            if (rsp_valid)
                counts[tag_bucket[rsp.tag]]--;
            if (req_valid && !pend_reject)
            begin
                counts[b]++;
                tag_bucket[req.tag] = b;
            end

            if (cfg_wr)
                cfg_model = cfg_in;
        end
    end

endmodule

`default_nettype wire

/* dv/order_filter_tb.sv */
`timescale 1ns/1ns
`default_nettype none

module order_filter_tb;

    import order_pkg::*;

    localparam int N_BUCKETS       = 16;
    localparam int BITS_PER_BUCKET = 3;
    localparam int NAME_W          = 256;

    // OP_RND takes a random address and has no table flags
    typedef enum logic [2:0] {OP_IDLE, OP_REQ, OP_RSP, OP_CFG, OP_BOTH, OP_RND} op_t;

    typedef struct packed {
        op_t               op;
        tag_t              tag;
        tag_t              rsp_tag;
        addr_t             addr;
        cfg_t              cfg;
        logic              exp_conflict;
        logic              exp_reject;
        logic [NAME_W-1:0] name;
    } row_t;

    logic              clk;
    logic              reset;
    logic              req_valid;
    req_t              req;
    logic              rsp_valid;
    rsp_t              rsp;
    logic              cfg_wr;
    cfg_t              cfg_in;
    logic              verdict_valid;
    verdict_t          verdict;
    stats_t            stats;
    logic              exp_check;
    logic              exp_conflict;
    logic              exp_reject;
    logic [NAME_W-1:0] exp_name;
    int                mismatch_count;
    int                error_count;
    int                cycle_limit = 0;
    row_t              rows[$];

    order_filter_top #(
        .N_BUCKETS       (N_BUCKETS),
        .BITS_PER_BUCKET (BITS_PER_BUCKET)
    ) order_filter_top_i (
        .clk           (clk),
        .reset         (reset),
        .req_valid     (req_valid),
        .req           (req),
        .rsp_valid     (rsp_valid),
        .rsp           (rsp),
        .cfg_wr        (cfg_wr),
        .cfg_in        (cfg_in),
        .verdict_valid (verdict_valid),
        .verdict       (verdict),
        .stats         (stats)
    );

    order_filter_checker #(
        .N_BUCKETS       (N_BUCKETS),
        .BITS_PER_BUCKET (BITS_PER_BUCKET),
        .NAME_W          (NAME_W)
    ) order_filter_checker_i (
        .clk            (clk),
        .reset          (reset),
        .req_valid      (req_valid),
        .req            (req),
        .rsp_valid      (rsp_valid),
        .rsp            (rsp),
        .cfg_wr         (cfg_wr),
        .cfg_in         (cfg_in),
        .verdict_valid  (verdict_valid),
        .verdict        (verdict),
        .stats          (stats),
        .exp_check      (exp_check),
        .exp_conflict   (exp_conflict),
        .exp_reject     (exp_reject),
        .exp_name       (exp_name),
        .mismatch_count (mismatch_count),
        .error_count    (error_count)
    );

    initial
    begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    task automatic add_row(input op_t op, input int tag, input int rsp_tag, input int low_addr,
                           input int cfg_bits, input int ec, input int er,
                           input logic [NAME_W-1:0] name);
        row_t        row;
        logic [31:0] upper;
        upper            = $urandom();
        row.op           = op;
        row.tag          = tag_t'(tag);
        row.rsp_tag      = tag_t'(rsp_tag);
        // Bits above the two hash fields never move a bucket
        row.addr         = (op == OP_RND) ? upper : {upper[31:8], 8'(low_addr)};
        row.cfg          = cfg_t'(cfg_bits);
        row.exp_conflict = (ec != 0);
        row.exp_reject   = (er != 0);
        row.name         = name;
        rows.push_back(row);
    endtask

    task automatic apply_row(input row_t row);
        req_valid    = (row.op == OP_REQ) || (row.op == OP_BOTH) || (row.op == OP_RND);
        req.tag      = row.tag;
        req.addr     = row.addr;
        rsp_valid    = (row.op == OP_RSP) || (row.op == OP_BOTH);
        rsp.tag      = row.rsp_tag;
        cfg_wr       = (row.op == OP_CFG);
        cfg_in       = row.cfg;
        exp_check    = (row.op == OP_REQ) || (row.op == OP_BOTH);
        exp_conflict = row.exp_conflict;
        exp_reject   = row.exp_reject;
        exp_name     = row.name;
    endtask

    // ==================================================
    // Stimulus table
    // ==================================================

    task automatic build_rows();
        // Distinct buckets and then a conflict that clears after both responses
        add_row(OP_REQ, 0, 0, 'h01, 0, 0, 0, "distinct_b1");
        add_row(OP_REQ, 1, 0, 'h02, 0, 0, 0, "distinct_b2");
        add_row(OP_REQ, 2, 0, 'h03, 0, 0, 0, "distinct_b3");
        add_row(OP_REQ, 3, 0, 'h11, 0, 1, 0, "conflict_b1");
        add_row(OP_RSP, 0, 0, 0, 0, 0, 0, "rsp_t0");
        add_row(OP_RSP, 0, 3, 0, 0, 0, 0, "rsp_t3");
        add_row(OP_REQ, 4, 0, 'h21, 0, 0, 0, "after_rsp_b1");
        add_row(OP_RSP, 0, 1, 0, 0, 0, 0, "rsp_t1");
        add_row(OP_RSP, 0, 2, 0, 0, 0, 0, "rsp_t2");
        add_row(OP_RSP, 0, 4, 0, 0, 0, 0, "rsp_t4");
        // Bucket 5 fills to 4 and rejects and then accepts after one response
        add_row(OP_REQ, 5, 0, 'h05, 0, 0, 0, "fill_1");
        add_row(OP_REQ, 6, 0, 'h15, 0, 1, 0, "fill_2");
        add_row(OP_REQ, 7, 0, 'h25, 0, 1, 0, "fill_3");
        add_row(OP_REQ, 8, 0, 'h35, 0, 1, 0, "fill_4");
        add_row(OP_REQ, 9, 0, 'h45, 0, 0, 1, "fill_reject");
        add_row(OP_RSP, 0, 5, 0, 0, 0, 0, "rsp_t5");
        add_row(OP_REQ, 9, 0, 'h55, 0, 1, 0, "refill_accept");
        add_row(OP_RSP, 0, 6, 0, 0, 0, 0, "rsp_t6");
        add_row(OP_RSP, 0, 7, 0, 0, 0, 0, "rsp_t7");
        add_row(OP_RSP, 0, 8, 0, 0, 0, 0, "rsp_t8");
        add_row(OP_RSP, 0, 9, 0, 0, 0, 0, "rsp_t9");
        // XOR hash maps to buckets 3 and 0 and then 3 again
        add_row(OP_CFG, 0, 0, 0, 'b11, 0, 0, "cfg_xor");
        add_row(OP_REQ, 0, 0, 'h12, 0, 0, 0, "xor_a");
        add_row(OP_REQ, 1, 0, 'h22, 0, 0, 0, "xor_b");
        add_row(OP_REQ, 2, 0, 'h30, 0, 1, 0, "xor_equal");
        add_row(OP_RSP, 0, 0, 0, 0, 0, 0, "rsp_t0");
        add_row(OP_RSP, 0, 1, 0, 0, 0, 0, "rsp_t1");
        add_row(OP_RSP, 0, 2, 0, 0, 0, 0, "rsp_t2");
        // Bucket 7 still rejects at 4 with conflicts off
        add_row(OP_CFG, 0, 0, 0, 'b00, 0, 0, "cfg_noconf");
        add_row(OP_REQ, 3, 0, 'h07, 0, 0, 0, "noconf_1");
        add_row(OP_REQ, 4, 0, 'h17, 0, 0, 0, "noconf_2");
        add_row(OP_REQ, 5, 0, 'h27, 0, 0, 0, "noconf_3");
        add_row(OP_REQ, 6, 0, 'h37, 0, 0, 0, "noconf_4");
        add_row(OP_REQ, 7, 0, 'h47, 0, 0, 1, "noconf_reject");
        add_row(OP_CFG, 0, 0, 0, 'b01, 0, 0, "cfg_default");
        // Request and response together still see the old count
        add_row(OP_BOTH, 8, 3, 'h57, 0, 0, 1, "same_cycle_full");
        add_row(OP_BOTH, 8, 4, 'h67, 0, 1, 0, "same_cycle_accept");
        add_row(OP_RSP, 0, 5, 0, 0, 0, 0, "rsp_t5");
        add_row(OP_RSP, 0, 6, 0, 0, 0, 0, "rsp_t6");
        add_row(OP_RSP, 0, 8, 0, 0, 0, 0, "rsp_t8");
        add_row(OP_IDLE, 0, 0, 0, 0, 0, 0, "idle");
        // Random addresses on free tags are checked against the model only
        for (int t = 10; t < 16; t++)
            add_row(OP_RND, t, 0, 0, 0, 0, 0, "random_req");
    endtask

    initial
    begin
        int   seed_value;
        row_t idle_row;
        seed_value = $urandom(32'h571fad4e);
        idle_row   = '0;
        reset      = 1'b1;
        apply_row(idle_row);
        build_rows();
        cycle_limit = 2 * rows.size() + 50;

        repeat (3) @(posedge clk);
        #1 reset = 1'b0;

        foreach (rows[i])
        begin
            @(posedge clk);
            #1;
            apply_row(rows[i]);
        end
        @(posedge clk);
        #1;
        apply_row(idle_row);

        // Let the last verdict reach the statistics
        repeat (4) @(posedge clk);
        $display("checks done: %0d mismatches, %0d other errors", mismatch_count, error_count);
        if (mismatch_count == 0 && error_count == 0)
            $display("*** PASSED ***");
        else
            $display("*** FAILED ***");
        $finish;
    end

    initial
    begin : watchdog
        int cycles;
        cycles = 0;
        wait (cycle_limit > 0);
        while (cycles < cycle_limit)
        begin
            @(posedge clk);
            cycles++;
        end
        $display("timeout: run did not finish within %0d cycles", cycle_limit);
        $display("checks done: %0d mismatches, %0d other errors", mismatch_count, error_count);
        $display("*** FAILED ***");
        $finish;
    end

endmodule

`default_nettype wire

/* order_filter.f */
source/order_pkg.sv
source/counting_filter.sv
source/tag_table.sv
source/order_tracker.sv
source/order_csr.sv
source/order_filter_top.sv
dv/order_filter_checker.sv
dv/order_filter_tb.sv

/* Makefile */
SIM      := verilator
TOP      := order_filter_tb
FILELIST := order_filter.f
OBJ_DIR  := obj_dir
FLAGS    := --binary --timing --assert --top-module $(TOP) --Mdir $(OBJ_DIR)

SOURCES  := $(shell cat $(FILELIST))
BIN      := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(SOURCES) $(FILELIST)
	$(SIM) $(FLAGS) -f $(FILELIST)

run: $(BIN)
	@out="$$(./$(BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF '*** PASSED ***'

clean:
	rm -rf $(OBJ_DIR)
